//--- compile.f
logic/cpuPkg.sv
logic/memPkg.sv
logic/regFile.sv
logic/alu.sv
logic/dataMem.sv
logic/controlUnit.sv
logic/datapath.sv
logic/execCore.sv
dv/execCoreTb.sv

//--- dv/execCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module execCoreTb;

   // Operation kinds the reference model knows
   typedef enum {kNop, kAdd, kAdds, kSub, kSubs, kAnd, kAnds, kOrr, kEor,
                 kAddi, kSubi, kLdur, kLdurb, kStur, kSturb} opKind;

   logic        clk;
   logic        rst;
   logic [31:0] instr;
   logic [3:0]  flags;
   logic        wbEn;
   logic [4:0]  wbReg;
   logic [63:0] wbData;

   // Shadow architectural state
   logic [63:0] shadowRegs [0:31];
   logic [7:0]  shadowMem [0:255];
   logic [3:0]  shadowFlags;

   int     errorCount;
   int     cycleCount;
   integer seed;

   execCore i_execCore (
      .clk    (clk),
      .rst    (rst),
      .instr  (instr),
      .flags  (flags),
      .wbEn   (wbEn),
      .wbReg  (wbReg),
      .wbData (wbData)
   );

   always #50 clk = ~clk;

   // Tests need about 270 cycles so 400 leaves margin
   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= 400) begin
         $display("Timeout: tests still running after %0d cycles", cycleCount);
         $display("Errors found");
         $finish;
      end
   end

   // R format fields opcode Rm shamt Rn Rd
   function automatic logic [31:0] encodeR(input logic [10:0] op, input logic [4:0] rm,
                                           input logic [4:0] rn, input logic [4:0] rd);
      return {op, rm, 6'b000000, rn, rd};
   endfunction

   // I format fields opcode Imm12 Rn Rd
   function automatic logic [31:0] encodeI(input logic [9:0] op, input logic [11:0] imm,
                                           input logic [4:0] rn, input logic [4:0] rd);
      return {op, imm, rn, rd};
   endfunction

   // D format fields opcode Daddr9 op2 Rn Rt
   function automatic logic [31:0] encodeD(input logic [10:0] op, input logic [8:0] offset,
                                           input logic [4:0] rn, input logic [4:0] rt);
      return {op, offset, 2'b00, rn, rt};
   endfunction

   function automatic logic [63:0] readShadow(input logic [4:0] r);
      return (r == 5'd31) ? 64'd0 : shadowRegs[r];
   endfunction

   // Little endian word read with the address wrapping inside 256 bytes
   function automatic logic [63:0] loadWord(input logic [63:0] addr);
      logic [63:0] value;
      logic [7:0]  idx;
      value = '0;
      for (int i = 0; i < 8; i++) begin
         idx = addr[7:0] + 8'(i);
         value[8*i +: 8] = shadowMem[idx];
      end
      return value;
   endfunction

   // Drive one instruction, check writeback now and prior flags
   task automatic issue(input opKind kind, input logic [4:0] rd, input logic [4:0] rn,
                        input logic [4:0] rm, input logic [11:0] imm);
      logic [63:0] a, b, res, addr;
      logic [64:0] wide;
      logic [31:0] word;
      logic [3:0]  newFlags;
      logic [7:0]  idx;
      logic        writes, setsFlags, expEn;
      int          nBytes;
      a = readShadow(rn);
      b = readShadow(rm);
      addr = a + {{55{imm[8]}}, imm[8:0]};
      res = '0;
      word = '0;
      writes = 1'b1;
      setsFlags = 1'b0;
      newFlags = shadowFlags;
      case (kind)
         kAdd, kAdds: begin
            word = encodeR((kind == kAdd) ? cpuPkg::opAdd : cpuPkg::opAdds, rm, rn, rd);
            wide = {1'b0, a} + {1'b0, b};
            res = wide[63:0];
            // Like signs in, other sign out
            newFlags[1] = (a[63] == b[63]) && (res[63] != a[63]);
            newFlags[0] = wide[64];
            setsFlags = (kind == kAdds);
         end
         kSub, kSubs: begin
            word = encodeR((kind == kSub) ? cpuPkg::opSub : cpuPkg::opSubs, rm, rn, rd);
            res = a - b;
            newFlags[1] = (a[63] != b[63]) && (res[63] != a[63]);
            // Carry set when no borrow
            newFlags[0] = (a >= b);
            setsFlags = (kind == kSubs);
         end
         kAnd, kAnds: begin
            word = encodeR((kind == kAnd) ? cpuPkg::opAnd : cpuPkg::opAnds, rm, rn, rd);
            res = a & b;
            newFlags[1:0] = 2'b00;
            setsFlags = (kind == kAnds);
         end
         kOrr: begin
            word = encodeR(cpuPkg::opOrr, rm, rn, rd);
            res = a | b;
         end
         kEor: begin
            word = encodeR(cpuPkg::opEor, rm, rn, rd);
            res = a ^ b;
         end
         kAddi: begin
            word = encodeI(cpuPkg::opAddi, imm, rn, rd);
            res = a + {52'd0, imm};
         end
         kSubi: begin
            word = encodeI(cpuPkg::opSubi, imm, rn, rd);
            res = a - {52'd0, imm};
         end
         kLdur: begin
            word = encodeD(cpuPkg::opLdur, imm[8:0], rn, rd);
            res = loadWord(addr);
         end
         kLdurb: begin
            word = encodeD(cpuPkg::opLdurb, imm[8:0], rn, rd);
            res = loadWord(addr) & 64'hff;
         end
         kStur, kSturb: begin
            word = encodeD((kind == kStur) ? cpuPkg::opStur : cpuPkg::opSturb,
                           imm[8:0], rn, rd);
            writes = 1'b0;
         end
         default: writes = 1'b0;
      endcase
      newFlags[3] = res[63];
      newFlags[2] = (res == '0);
      expEn = writes && (rd != 5'd31);

      @(posedge clk);
      instr <= word;
      @(negedge clk);

      // Flags show every instruction before this one
      assert (flags === shadowFlags) else begin
         errorCount++;
         $display("Fail %0t: flags %b, expected %b before %s", $time, flags, shadowFlags,
                  kind.name());
      end
      assert (wbEn === expEn) else begin
         errorCount++;
         $display("Fail %0t: wbEn %b, expected %b for %s", $time, wbEn, expEn, kind.name());
      end
      assert (wbReg === rd) else begin
         errorCount++;
         $display("Fail %0t: wbReg %0d, expected %0d for %s", $time, wbReg, rd, kind.name());
      end
      if (expEn) begin
         assert (wbData === res) else begin
            errorCount++;
            $display("Fail %0t: wbData %h, expected %h for %s", $time, wbData, res,
                     kind.name());
         end
         shadowRegs[rd] = res;
      end

      // Store data comes from the Rt register
      if (kind == kStur || kind == kSturb) begin
         b = readShadow(rd);
         nBytes = (kind == kStur) ? 8 : 1;
         for (int i = 0; i < nBytes; i++) begin
            idx = addr[7:0] + 8'(i);
            shadowMem[idx] = b[8*i +: 8];
         end
      end
      if (setsFlags) begin
         shadowFlags = newFlags;
      end
   endtask

   task automatic testReset();
      issue(kNop, 5'd0, 5'd0, 5'd0, 12'd0);
      // All registers read back zero
      for (int r = 0; r < 32; r++) begin
         issue(kAdd, 5'd1, 5'(r), 5'd31, 12'd0);
      end
   endtask

   task automatic testImmediate();
      issue(kAddi, 5'd2, 5'd31, 5'd0, 12'h7ff);
      issue(kAddi, 5'd3, 5'd2, 5'd0, 12'hfff);
      issue(kSubi, 5'd4, 5'd3, 5'd0, 12'h005);
      // Zero extended immediate, so all ones
      issue(kSubi, 5'd5, 5'd31, 5'd0, 12'h001);
      issue(kAddi, 5'd31, 5'd2, 5'd0, 12'h001);
      issue(kAdd, 5'd6, 5'd31, 5'd2, 12'd0);
   endtask

   task automatic testLogic();
      issue(kAddi, 5'd7, 5'd31, 5'd0, 12'habc);
      issue(kSubi, 5'd8, 5'd31, 5'd0, 12'h123);
      issue(kAdd, 5'd9, 5'd7, 5'd8, 12'd0);
      issue(kSub, 5'd10, 5'd7, 5'd8, 12'd0);
      issue(kAnd, 5'd11, 5'd8, 5'd7, 12'd0);
      issue(kOrr, 5'd12, 5'd7, 5'd8, 12'd0);
      issue(kEor, 5'd13, 5'd7, 5'd8, 12'd0);
      issue(kAdds, 5'd11, 5'd8, 5'd8, 12'd0);
      issue(kAdd, 5'd12, 5'd7, 5'd7, 12'd0);
      issue(kSubs, 5'd12, 5'd7, 5'd7, 12'd0);
      issue(kSub, 5'd13, 5'd8, 5'd7, 12'd0);
      issue(kAnds, 5'd13, 5'd8, 5'd5, 12'd0);
      issue(kSubs, 5'd13, 5'd7, 5'd8, 12'd0);
      issue(kEor, 5'd12, 5'd8, 5'd8, 12'd0);
   endtask

   task automatic testWordMem();
      issue(kAddi, 5'd14, 5'd31, 5'd0, 12'h040);
      issue(kStur, 5'd9, 5'd14, 5'd0, 12'h008);
      // Offset of minus 16 in nine bits
      issue(kStur, 5'd8, 5'd14, 5'd0, 12'h1f0);
      issue(kLdur, 5'd15, 5'd14, 5'd0, 12'h008);
      issue(kLdur, 5'd16, 5'd14, 5'd0, 12'h1f0);
      // Word that wraps past the top byte
      issue(kAddi, 5'd17, 5'd31, 5'd0, 12'h0fc);
      issue(kStur, 5'd10, 5'd17, 5'd0, 12'h000);
      issue(kLdur, 5'd18, 5'd17, 5'd0, 12'h000);
      issue(kLdur, 5'd18, 5'd17, 5'd0, 12'h004);
   endtask

   task automatic testByteMem();
      issue(kSturb, 5'd7, 5'd14, 5'd0, 12'h009);
      issue(kLdur, 5'd19, 5'd14, 5'd0, 12'h008);
      issue(kLdurb, 5'd20, 5'd14, 5'd0, 12'h009);
      issue(kLdurb, 5'd20, 5'd14, 5'd0, 12'h008);
   endtask

   task automatic testRandomFlags();
      logic [7:0] rnd;
      logic [3:0] offA, offB;
      // Most negative value from one byte store
      issue(kAddi, 5'd21, 5'd31, 5'd0, 12'h080);
      issue(kAddi, 5'd22, 5'd31, 5'd0, 12'h0c0);
      issue(kSturb, 5'd21, 5'd22, 5'd0, 12'h007);
      issue(kLdur, 5'd23, 5'd22, 5'd0, 12'h000);
      issue(kSubs, 5'd24, 5'd31, 5'd23, 12'd0);
      issue(kAdds, 5'd24, 5'd23, 5'd23, 12'd0);
      // Most positive plus small value
      issue(kSubi, 5'd26, 5'd23, 5'd0, 12'h001);
      issue(kAdds, 5'd24, 5'd26, 5'd21, 12'd0);
      // Random bytes at 0x80 to 0x9f
      issue(kAddi, 5'd25, 5'd31, 5'd0, 12'h080);
      for (int k = 0; k < 32; k++) begin
         rnd = 8'($random(seed));
         issue(kAddi, 5'd21, 5'd31, 5'd0, {4'd0, rnd});
         issue(kSturb, 5'd21, 5'd25, 5'd0, 12'(k));
      end
      // Overlapping word loads give the operands
      for (int n = 0; n < 40; n++) begin
         offA = 4'($random(seed));
         offB = 4'($random(seed));
         issue(kLdur, 5'd26, 5'd25, 5'd0, {8'd0, offA});
         issue(kLdur, 5'd27, 5'd25, 5'd0, {8'd0, offB});
         if ($random(seed) & 1) begin
            issue(kAdds, 5'd28, 5'd26, 5'd27, 12'd0);
         end else begin
            issue(kSubs, 5'd28, 5'd26, 5'd27, 12'd0);
         end
      end
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      instr = '0;
      errorCount = 0;
      cycleCount = 0;
      seed = 32'hbb23_a4cc;
      shadowFlags = '0;
      for (int i = 0; i < 32; i++) begin
         shadowRegs[5'(i)] = '0;
      end
      for (int i = 0; i < 256; i++) begin
         shadowMem[8'(i)] = '0;
      end

      repeat (3) @(posedge clk);
      rst <= 1'b0;

      testReset();
      testImmediate();
      testLogic();
      testWordMem();
      testByteMem();
      testRandomFlags();
      // Idle cycle shows the last flags
      issue(kNop, 5'd0, 5'd0, 5'd0, 12'd0);

      $display("Errors: %0d", errorCount);
      if (errorCount == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
   input  logic [cpuPkg::dataWidth-1:0] a,
   input  logic [cpuPkg::dataWidth-1:0] b,
   input  logic [2:0]                   cntrl,
   output logic [cpuPkg::dataWidth-1:0] result,
   output logic                         negative,
   output logic                         zero,
   output logic                         overflow,
   output logic                         carryOut
);

   // Adder operand after optional inversion
   logic [cpuPkg::dataWidth-1:0] bOperand;
   // Carry in of one turns the inverted add into a subtract
   logic                         carryIn;
   // One extra bit to catch the carry out
   logic [cpuPkg::dataWidth:0]   sum;
   // High for add and subtract
   logic                         isArith;

   assign isArith  = (cntrl == cpuPkg::aluAdd) || (cntrl == cpuPkg::aluSub);
   assign carryIn  = (cntrl == cpuPkg::aluSub);
   assign bOperand = carryIn ? ~b : b;

   // Shared adder for add and subtract
   assign sum = {1'b0, a} + {1'b0, bOperand}
              + {{cpuPkg::dataWidth{1'b0}}, carryIn};

   // Result select
   always_comb begin
      case (cntrl)
         cpuPkg::aluPassB: result = b;
         cpuPkg::aluAdd:   result = sum[cpuPkg::dataWidth-1:0];
         cpuPkg::aluSub:   result = sum[cpuPkg::dataWidth-1:0];
         cpuPkg::aluAnd:   result = a & b;
         cpuPkg::aluOrr:   result = a | b;
         cpuPkg::aluEor:   result = a ^ b;
         // Unused codes give zero
         default:          result = '0;
      endcase
   end

   // N and Z follow the result for every operation
   assign negative = result[cpuPkg::dataWidth-1];
   assign zero     = (result == '0);

   // Carry straight out of the adder
   assign carryOut = isArith & sum[cpuPkg::dataWidth];

   // Signed overflow when both adder inputs share a sign
   // and the sum flips it
   assign overflow = isArith
                   & (a[cpuPkg::dataWidth-1] == bOperand[cpuPkg::dataWidth-1])
                   & (sum[cpuPkg::dataWidth-1] != a[cpuPkg::dataWidth-1]);

endmodule

`default_nettype wire

//--- logic/controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
   input  logic [31:0]                     instr,
   output logic [cpuPkg::regAddrWidth-1:0] Rd,
   output logic [cpuPkg::regAddrWidth-1:0] Rm,
   output logic [cpuPkg::regAddrWidth-1:0] Rn,
   output logic [8:0]                      Daddr9,
   output logic [11:0]                     Imm12,
   output logic                            Reg2Loc,
   output logic                            ALUSrc,
   output logic                            ChooseImm,
   output logic                            MemToReg,
   output logic                            RegWrite,
   output logic                            MemWrite,
   output logic                            MemRead,
   output logic                            xferByte,
   output logic [2:0]                      ALUOp,
   output logic                            setFlags
);

   // Fixed field positions across R, I and D formats
   assign Rd     = instr[4:0];
   assign Rn     = instr[9:5];
   assign Rm     = instr[20:16];
   assign Daddr9 = instr[20:12];
   assign Imm12  = instr[21:10];

   always_comb begin
      // Safe defaults write nothing
      Reg2Loc   = 1'b1;
      ALUSrc    = 1'b0;
      ChooseImm = 1'b0;
      MemToReg  = 1'b0;
      RegWrite  = 1'b0;
      MemWrite  = 1'b0;
      MemRead   = 1'b0;
      xferByte  = 1'b0;
      ALUOp     = cpuPkg::aluPassB;
      setFlags  = 1'b0;

      case (instr[31:21])
         // Register to register
         cpuPkg::opAdd: begin
            RegWrite = 1'b1;
            ALUOp    = cpuPkg::aluAdd;
         end
         cpuPkg::opSub: begin
            RegWrite = 1'b1;
            ALUOp    = cpuPkg::aluSub;
         end
         cpuPkg::opAnd: begin
            RegWrite = 1'b1;
            ALUOp    = cpuPkg::aluAnd;
         end
         cpuPkg::opOrr: begin
            RegWrite = 1'b1;
            ALUOp    = cpuPkg::aluOrr;
         end
         cpuPkg::opEor: begin
            RegWrite = 1'b1;
            ALUOp    = cpuPkg::aluEor;
         end
         // Flag setting forms
         cpuPkg::opAdds: begin
            RegWrite = 1'b1;
            ALUOp    = cpuPkg::aluAdd;
            setFlags = 1'b1;
         end
         cpuPkg::opSubs: begin
            RegWrite = 1'b1;
            ALUOp    = cpuPkg::aluSub;
            setFlags = 1'b1;
         end
         cpuPkg::opAnds: begin
            RegWrite = 1'b1;
            ALUOp    = cpuPkg::aluAnd;
            setFlags = 1'b1;
         end
         // Loads address Rn plus sign extended Daddr9
         cpuPkg::opLdur, cpuPkg::opLdurb: begin
            ALUSrc   = 1'b1;
            MemToReg = 1'b1;
            RegWrite = 1'b1;
            MemRead  = 1'b1;
            xferByte = (instr[31:21] == cpuPkg::opLdurb);
            ALUOp    = cpuPkg::aluAdd;
         end
         // Stores read the Rd field as data
         cpuPkg::opStur, cpuPkg::opSturb: begin
            Reg2Loc  = 1'b0;
            ALUSrc   = 1'b1;
            MemWrite = 1'b1;
            xferByte = (instr[31:21] == cpuPkg::opSturb);
            ALUOp    = cpuPkg::aluAdd;
         end
         default: begin
            // I format has a 10 bit opcode
            if (instr[31:22] == cpuPkg::opAddi || instr[31:22] == cpuPkg::opSubi) begin
               ChooseImm = 1'b1;
               RegWrite  = 1'b1;
               ALUOp     = (instr[31:22] == cpuPkg::opSubi) ? cpuPkg::aluSub : cpuPkg::aluAdd;
            end
         end
      endcase
   end

endmodule

`default_nettype wire

//--- logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

   // Register and ALU width
   localparam int dataWidth = 64;
   // Register number width
   localparam int regAddrWidth = 5;
   // X31 reads zero and drops writes
   localparam logic [regAddrWidth-1:0] zeroReg = 5'd31;

   // ALU operation codes
   localparam logic [2:0] aluPassB = 3'b000;
   localparam logic [2:0] aluAdd   = 3'b010;
   localparam logic [2:0] aluSub   = 3'b011;
   localparam logic [2:0] aluAnd   = 3'b100;
   localparam logic [2:0] aluOrr   = 3'b101;
   localparam logic [2:0] aluEor   = 3'b110;

   // R format opcode in instr[31:21]
   localparam logic [10:0] opAdd  = 11'b10001011000;
   localparam logic [10:0] opAdds = 11'b10101011000;
   localparam logic [10:0] opSub  = 11'b11001011000;
   localparam logic [10:0] opSubs = 11'b11101011000;
   localparam logic [10:0] opAnd  = 11'b10001010000;
   localparam logic [10:0] opAnds = 11'b11101010000;
   localparam logic [10:0] opOrr  = 11'b10101010000;
   localparam logic [10:0] opEor  = 11'b11001010000;

   // I format opcode in instr[31:22]
   localparam logic [9:0] opAddi = 10'b1001000100;
   localparam logic [9:0] opSubi = 10'b1101000100;

   // D format opcode in instr[31:21]
   localparam logic [10:0] opLdur  = 11'b11111000010;
   localparam logic [10:0] opStur  = 11'b11111000000;
   localparam logic [10:0] opLdurb = 11'b00111000010;
   localparam logic [10:0] opSturb = 11'b00111000000;

endpackage

`default_nettype wire

//--- logic/dataMem.sv
`timescale 1ns/1ns
`default_nettype none

module dataMem (
   input  logic                         clk,
   input  logic                         rst,
   input  logic [cpuPkg::dataWidth-1:0] address,
   input  logic                         writeEnable,
   input  logic                         readEnable,
   input  logic [cpuPkg::dataWidth-1:0] writeData,
   input  logic [3:0]                   xferSize,
   output logic [cpuPkg::dataWidth-1:0] readData
);

   // Little endian byte array
   logic [7:0] mem [0:memPkg::memBytes-1];

   // Only the low address bits are decoded
   logic [memPkg::memAddrWidth-1:0] baseAddr;
   assign baseAddr = address[memPkg::memAddrWidth-1:0];

   // Combinational word read that wraps past the top byte
   always_comb begin
      readData = '0;
      if (readEnable) begin
         for (int i = 0; i < memPkg::xferWord; i++) begin
            readData[8*i +: 8] = mem[baseAddr + (memPkg::memAddrWidth)'(i)];
         end
      end
   end

   // Rising edge write of 8 bytes or the low byte
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < memPkg::memBytes; i++) begin
            mem[i] <= '0;
         end
      end else if (writeEnable) begin
         if (xferSize == memPkg::xferWord) begin
            for (int i = 0; i < memPkg::xferWord; i++) begin
               mem[baseAddr + (memPkg::memAddrWidth)'(i)] <= writeData[8*i +: 8];
            end
         end else if (xferSize == memPkg::xferByte1) begin
            // Byte store touches one location only
            mem[baseAddr] <= writeData[7:0];
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath (
   input  logic                            clk,
   input  logic                            rst,
   output logic [3:0]                      flags,
   // Instruction fields
   input  logic [cpuPkg::regAddrWidth-1:0] Rd,
   input  logic [cpuPkg::regAddrWidth-1:0] Rm,
   input  logic [cpuPkg::regAddrWidth-1:0] Rn,
   input  logic [8:0]                      Daddr9,
   input  logic [11:0]                     Imm12,
   // Control levels
   input  logic                            Reg2Loc,
   input  logic                            ALUSrc,
   input  logic                            ChooseImm,
   input  logic                            MemToReg,
   input  logic                            RegWrite,
   input  logic                            MemWrite,
   input  logic                            MemRead,
   input  logic                            xferByte,
   input  logic [2:0]                      ALUOp,
   input  logic                            setFlags,
   // Writeback view
   output logic                            wbEn,
   output logic [cpuPkg::regAddrWidth-1:0] wbReg,
   output logic [cpuPkg::dataWidth-1:0]    wbData
);

   logic [cpuPkg::regAddrWidth-1:0] readRegB;
   logic [cpuPkg::dataWidth-1:0]    regA, regB;
   logic [cpuPkg::dataWidth-1:0]    daddrExt, immExt, aluB;
   logic [cpuPkg::dataWidth-1:0]    aluOut, memOut, loadData;
   logic [3:0]                      aluFlags;
   logic [3:0]                      xferSize;

   // Stores read Rd as the data register, others read Rm
   assign readRegB = Reg2Loc ? Rm : Rd;

   regFile i_regFile (
      .clk       (clk),
      .rst       (rst),
      .readReg1  (Rn),
      .readReg2  (readRegB),
      .writeReg  (Rd),
      .writeData (wbData),
      .regWrite  (RegWrite),
      .readData1 (regA),
      .readData2 (regB)
   );

   // Signed address offset and unsigned arithmetic immediate
   assign daddrExt = {{(cpuPkg::dataWidth-9){Daddr9[8]}}, Daddr9};
   assign immExt   = {{(cpuPkg::dataWidth-12){1'b0}}, Imm12};

   // Immediate select wins over offset select for the second ALU operand
   assign aluB = ChooseImm ? immExt : (ALUSrc ? daddrExt : regB);

   alu i_alu (
      .a        (regA),
      .b        (aluB),
      .cntrl    (ALUOp),
      .result   (aluOut),
      .negative (aluFlags[3]),
      .zero     (aluFlags[2]),
      .overflow (aluFlags[1]),
      .carryOut (aluFlags[0])
   );

   // N Z V C flags loaded only by the S forms
   always_ff @(posedge clk) begin
      if (rst) begin
         flags <= '0;
      end else if (setFlags) begin
         flags <= aluFlags;
      end
   end

   // One byte or a full word
   assign xferSize = xferByte ? memPkg::xferByte1 : memPkg::xferWord;

   dataMem i_dataMem (
      .clk         (clk),
      .rst         (rst),
      .address     (aluOut),
      .writeEnable (MemWrite),
      .readEnable  (MemRead),
      .writeData   (regB),
      .xferSize    (xferSize),
      .readData    (memOut)
   );

   // Byte loads keep the low byte only
   assign loadData = xferByte ? {{(cpuPkg::dataWidth-8){1'b0}}, memOut[7:0]} : memOut;

   // Writeback select
   assign wbData = MemToReg ? loadData : aluOut;
   assign wbReg  = Rd;
   // X31 never shows as a real write
   assign wbEn   = RegWrite && (Rd != cpuPkg::zeroReg);

endmodule

`default_nettype wire

//--- logic/execCore.sv
`timescale 1ns/1ns
`default_nettype none

module execCore (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [31:0]                     instr,
   output logic [3:0]                      flags,
   output logic                            wbEn,
   output logic [cpuPkg::regAddrWidth-1:0] wbReg,
   output logic [cpuPkg::dataWidth-1:0]    wbData
);

   // Decoded fields
   logic [cpuPkg::regAddrWidth-1:0] Rd, Rm, Rn;
   logic [8:0]                      Daddr9;
   logic [11:0]                     Imm12;
   // Decoded control levels
   logic Reg2Loc, ALUSrc, ChooseImm, MemToReg;
   logic RegWrite, MemWrite, MemRead, xferByte, setFlags;
   logic [2:0] ALUOp;

   controlUnit i_controlUnit (
      .instr     (instr),
      .Rd        (Rd),
      .Rm        (Rm),
      .Rn        (Rn),
      .Daddr9    (Daddr9),
      .Imm12     (Imm12),
      .Reg2Loc   (Reg2Loc),
      .ALUSrc    (ALUSrc),
      .ChooseImm (ChooseImm),
      .MemToReg  (MemToReg),
      .RegWrite  (RegWrite),
      .MemWrite  (MemWrite),
      .MemRead   (MemRead),
      .xferByte  (xferByte),
      .ALUOp     (ALUOp),
      .setFlags  (setFlags)
   );

   datapath i_datapath (
      .clk       (clk),
      .rst       (rst),
      .flags     (flags),
      .Rd        (Rd),
      .Rm        (Rm),
      .Rn        (Rn),
      .Daddr9    (Daddr9),
      .Imm12     (Imm12),
      .Reg2Loc   (Reg2Loc),
      .ALUSrc    (ALUSrc),
      .ChooseImm (ChooseImm),
      .MemToReg  (MemToReg),
      .RegWrite  (RegWrite),
      .MemWrite  (MemWrite),
      .MemRead   (MemRead),
      .xferByte  (xferByte),
      .ALUOp     (ALUOp),
      .setFlags  (setFlags),
      .wbEn      (wbEn),
      .wbReg     (wbReg),
      .wbData    (wbData)
   );

endmodule

`default_nettype wire

//--- logic/memPkg.sv
`default_nettype none

package memPkg;

   // Data memory size in bytes
   localparam int memBytes = 256;
   // Address bits actually decoded
   localparam int memAddrWidth = 8;

   // Transfer size codes equal the byte count
   localparam logic [3:0] xferWord  = 4'b1000;
   localparam logic [3:0] xferByte1 = 4'b0001;

endpackage

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
   input  logic                             clk,
   input  logic                             rst,
   input  logic [cpuPkg::regAddrWidth-1:0]  readReg1,
   input  logic [cpuPkg::regAddrWidth-1:0]  readReg2,
   input  logic [cpuPkg::regAddrWidth-1:0]  writeReg,
   input  logic [cpuPkg::dataWidth-1:0]     writeData,
   input  logic                             regWrite,
   output logic [cpuPkg::dataWidth-1:0]     readData1,
   output logic [cpuPkg::dataWidth-1:0]     readData2
);

   // Storage for X0 to X30 only
   logic [cpuPkg::dataWidth-1:0] regs [0:cpuPkg::zeroReg-1];

   // Read port A forces X31 to zero
   assign readData1 = (readReg1 == cpuPkg::zeroReg) ? '0 : regs[readReg1];

   // Read port B forces X31 to zero
   assign readData2 = (readReg2 == cpuPkg::zeroReg) ? '0 : regs[readReg2];

   // Single write port on the rising edge
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < cpuPkg::zeroReg; i++) begin
            regs[i] <= '0;
         end
      end else if (regWrite && (writeReg != cpuPkg::zeroReg)) begin
         // Writes aimed at X31 are dropped
         regs[writeReg] <= writeData;
      end
   end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the execCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -f compile.f --top-module execCoreTb -o execCoreSim

output=$(./obj_dir/execCoreSim)
echo "$output"

if echo "$output" | grep -qx "No errors"; then
   exit 0
else
   exit 1
fi
